// File: hw/dist_plane.sv
`timescale 1ns/1ps
`include "lbm_consts.svh"

module dist_plane (
    input  logic                clk,
    input  lbm_pkg::cell_addr_t raddr,
    input  logic                rbank,
    input  lbm_pkg::cell_addr_t waddr,
    input  logic                wbank,
    input  logic [1:0]          we,
    input  lbm_pkg::dist_t      wdata,
    output lbm_pkg::dist_t      rdata
);

    // one direction, both time levels
    lbm_pkg::dist_t mem [2][`LBM_CELLS];

    always_ff @(posedge clk)
    begin
        // we[0] hits the bank on wbank
        if (we[0])
            mem[wbank][waddr] <= wdata;
        // we[1] mirrors into the other bank, init fills both at once
        if (we[1])
            mem[!wbank][waddr] <= wdata;
        // registered read, data one cycle after the address
        rdata <= mem[rbank][raddr];
    end

endmodule

// File: hw/lbm_consts.svh
`ifndef LBM_CONSTS_SVH
`define LBM_CONSTS_SVH

// grid shape, row 0 at the north edge
`define LBM_WIDTH 8
`define LBM_HEIGHT 6

// total cells in one bank
`define LBM_CELLS (`LBM_WIDTH * `LBM_HEIGHT)

// row-major cell index width
`define LBM_ADDR_W 6

// column counter width
`define LBM_COL_W 3

// one distribution value
`define LBM_DATA_W 16

// d2q9 directions, rest plus eight movers
`define LBM_DIRS 9

`endif

// File: hw/lbm_pkg.sv
`include "lbm_consts.svh"

package lbm_pkg;

    // single distribution value
    typedef logic [`LBM_DATA_W-1:0] dist_t;

    // all nine directions of one cell
    // 0 rest, then n ne e se s sw w nw
    typedef dist_t [`LBM_DIRS-1:0] dist_vec_t;

    // row * LBM_WIDTH + column
    typedef logic [`LBM_ADDR_W-1:0] cell_addr_t;

    // sweep phases
    typedef enum logic [2:0] {
        IDLE,
        INIT,
        STREAM,
        BOUNCE,
        CLEAR
    } phase_t;

    // command opcodes
    typedef enum logic {
        OP_INIT,
        OP_STEP
    } cmd_op_t;

endpackage

// File: hw/lbm_solver.sv
`timescale 1ns/1ps
`include "lbm_consts.svh"

module lbm_solver (
    input  logic                   clk,
    input  logic                   arst_n,
    // command handshake
    input  logic                   cmd_valid,
    input  lbm_pkg::cmd_op_t       cmd_op,
    output logic                   cmd_ready,
    // stable while a sweep runs
    input  logic [`LBM_CELLS-1:0]  barriers,
    input  lbm_pkg::dist_vec_t     init_dist,
    // readout request
    input  logic                   rd_valid,
    input  lbm_pkg::cell_addr_t    rd_addr,
    output logic                   rd_ready,
    // readout response
    output logic                   rsp_valid,
    output lbm_pkg::dist_vec_t     rsp_data,
    input  logic                   rsp_ready
);

    ////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////

    logic                                idle;
    logic                                bank_cur;
    lbm_pkg::cell_addr_t                 cell_idx;
    logic [`LBM_COL_W-1:0]               cell_col;
    lbm_pkg::cell_addr_t [`LBM_DIRS-1:0] up_addr;
    logic [`LBM_DIRS-1:0]                up_ok;
    lbm_pkg::cell_addr_t [`LBM_DIRS-1:0] plane_raddr;
    lbm_pkg::cell_addr_t [`LBM_DIRS-1:0] plane_waddr;
    logic [`LBM_DIRS-1:0][1:0]           plane_we;
    lbm_pkg::dist_vec_t                  plane_wdata;
    lbm_pkg::dist_vec_t                  plane_q;
    lbm_pkg::cell_addr_t                 rd_read_addr;
    logic                                rd_fire;

    sweep_sequencer sweep_sequencer_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .barriers     (barriers),
        .init_dist    (init_dist),
        .up_addr      (up_addr),
        .up_ok        (up_ok),
        .rd_read_addr (rd_read_addr),
        .rd_fire      (rd_fire),
        .plane_q      (plane_q),
        .cmd_ready    (cmd_ready),
        .idle         (idle),
        .cell_idx     (cell_idx),
        .cell_col     (cell_col),
        .plane_raddr  (plane_raddr),
        .plane_waddr  (plane_waddr),
        .plane_we     (plane_we),
        .plane_wdata  (plane_wdata),
        .bank_cur     (bank_cur)
    );

    neighbor_map neighbor_map_i (
        .cell_idx (cell_idx),
        .cell_col (cell_col),
        .up_addr  (up_addr),
        .up_ok    (up_ok)
    );

    // one plane per direction
    // reads hit the current bank, sweep writes the next one
    for (genvar d = 0; d < `LBM_DIRS; d++)
    begin : g_plane
        dist_plane dist_plane_i (
            .clk   (clk),
            .raddr (plane_raddr[d]),
            .rbank (bank_cur),
            .waddr (plane_waddr[d]),
            .wbank (~bank_cur),
            .we    (plane_we[d]),
            .wdata (plane_wdata[d]),
            .rdata (plane_q[d])
        );
    end

    readout_port readout_port_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .idle         (idle),
        .rd_valid     (rd_valid),
        .rd_addr      (rd_addr),
        .rsp_ready    (rsp_ready),
        .plane_q      (plane_q),
        .rd_ready     (rd_ready),
        .rd_read_addr (rd_read_addr),
        .rd_fire      (rd_fire),
        .rsp_valid    (rsp_valid),
        .rsp_data     (rsp_data)
    );

endmodule

// File: hw/neighbor_map.sv
`timescale 1ns/1ps
`include "lbm_consts.svh"

module neighbor_map (
    input  lbm_pkg::cell_addr_t                 cell_idx,
    input  logic [`LBM_COL_W-1:0]               cell_col,
    output lbm_pkg::cell_addr_t [`LBM_DIRS-1:0] up_addr,
    output logic [`LBM_DIRS-1:0]                up_ok
);

    // direction offsets, rows grow towards the south
    // rest, n, ne, e, se, s, sw, w, nw
    localparam int DX [`LBM_DIRS] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
    localparam int DY [`LBM_DIRS] = '{0, -1, -1, 0, 1, 1, 1, 0, -1};

    always_comb
    begin
        for (int d = 0; d < `LBM_DIRS; d++)
        begin
            // source cell sits one step against the travel direction
            up_addr[d] = lbm_pkg::cell_addr_t'(int'(cell_idx) - DY[d] * `LBM_WIDTH - DX[d]);
            up_ok[d] = 1'b1;
            // eastward movers come from the west column
            if (DX[d] > 0 && cell_col == '0)
                up_ok[d] = 1'b0;
            // westward movers come from the east column
            if (DX[d] < 0 && cell_col == `LBM_COL_W'(`LBM_WIDTH - 1))
                up_ok[d] = 1'b0;
            // southward movers, nothing above row 0
            if (DY[d] > 0 && cell_idx < `LBM_WIDTH)
                up_ok[d] = 1'b0;
            // northward movers, nothing below the last row
            if (DY[d] < 0 && cell_idx >= `LBM_CELLS - `LBM_WIDTH)
                up_ok[d] = 1'b0;
        end
    end

endmodule

// File: hw/readout_port.sv
`timescale 1ns/1ps

module readout_port (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                idle,
    input  logic                rd_valid,
    input  lbm_pkg::cell_addr_t rd_addr,
    input  logic                rsp_ready,
    input  lbm_pkg::dist_vec_t  plane_q,
    output logic                rd_ready,
    output lbm_pkg::cell_addr_t rd_read_addr,
    output logic                rd_fire,
    output logic                rsp_valid,
    output lbm_pkg::dist_vec_t  rsp_data
);

    // memory stage tracking
    logic                mem_vld;
    logic                mem_move;
    logic                acc;
    lbm_pkg::cell_addr_t addr_q;

    // memory stage drains when the response slot is empty or being taken
    assign mem_move = mem_vld && (!rsp_valid || rsp_ready);
    assign rd_ready = idle && (!mem_vld || mem_move);
    assign acc = rd_valid && rd_ready;

    // a stalled memory stage keeps re-reading its own address
    assign rd_read_addr = acc ? rd_addr : addr_q;
    // planes busy for the readout, holds off new commands
    assign rd_fire = acc || (mem_vld && !mem_move);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mem_vld <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            if (acc)
                mem_vld <= 1'b1;
            else if (mem_move)
                mem_vld <= 1'b0;
            if (mem_move)
                rsp_valid <= 1'b1;
            else if (rsp_ready)
                rsp_valid <= 1'b0;
        end
    end

    // payload only, held while stalled
    always_ff @(posedge clk)
    begin
        if (acc)
            addr_q <= rd_addr;
        if (mem_move)
            rsp_data <= plane_q;
    end

endmodule

// File: hw/sweep_sequencer.sv
`timescale 1ns/1ps
`include "lbm_consts.svh"

module sweep_sequencer (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                cmd_valid,
    input  lbm_pkg::cmd_op_t                    cmd_op,
    input  logic [`LBM_CELLS-1:0]               barriers,
    input  lbm_pkg::dist_vec_t                  init_dist,
    input  lbm_pkg::cell_addr_t [`LBM_DIRS-1:0] up_addr,
    input  logic [`LBM_DIRS-1:0]                up_ok,
    input  lbm_pkg::cell_addr_t                 rd_read_addr,
    input  logic                                rd_fire,
    input  lbm_pkg::dist_vec_t                  plane_q,
    output logic                                cmd_ready,
    output logic                                idle,
    output lbm_pkg::cell_addr_t                 cell_idx,
    output logic [`LBM_COL_W-1:0]               cell_col,
    output lbm_pkg::cell_addr_t [`LBM_DIRS-1:0] plane_raddr,
    output lbm_pkg::cell_addr_t [`LBM_DIRS-1:0] plane_waddr,
    output logic [`LBM_DIRS-1:0][1:0]           plane_we,
    output lbm_pkg::dist_vec_t                  plane_wdata,
    output logic                                bank_cur
);

    // opposite direction, rest maps to itself
    localparam int OPP [`LBM_DIRS] = '{0, 5, 6, 7, 8, 1, 2, 3, 4};

    lbm_pkg::phase_t                     phase;
    lbm_pkg::cell_addr_t                 next_idx;
    logic [`LBM_COL_W-1:0]               next_col;
    logic                                last_cell;
    logic                                cmd_fire;
    // stream write stage
    logic                                wr_pend;
    lbm_pkg::cell_addr_t                 pend_cell;
    logic [`LBM_DIRS-1:0]                pend_ok;
    // bounce write stage
    logic                                bnc_wr;
    lbm_pkg::cell_addr_t [`LBM_DIRS-1:0] pend_up;
    logic [`LBM_DIRS-1:0]                pend_en;
    logic [`LBM_DIRS-1:0]                up_fluid;

    assign idle = (phase == lbm_pkg::IDLE);
    // no new sweep while the readout owns the planes
    assign cmd_ready = idle && !rd_fire;
    assign cmd_fire = cmd_valid && cmd_ready;
    assign last_cell = (cell_idx == lbm_pkg::cell_addr_t'(`LBM_CELLS - 1));
    assign next_idx = cell_idx + 1'b1;
    assign next_col = (cell_col == `LBM_COL_W'(`LBM_WIDTH - 1)) ? '0 : cell_col + 1'b1;

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    // stream and bounce both read the current bank at the upstream cells
    // of the counter cell; that value is exactly what streaming put into
    // the next bank at the counter cell
    always_comb
    begin
        for (int d = 0; d < `LBM_DIRS; d++)
        begin
            up_fluid[d] = up_ok[d] && !barriers[up_addr[d]];
            plane_raddr[d] = idle ? rd_read_addr : up_addr[d];
        end
    end

    ////////////////////////////////////////////////////////////
    // phase fsm and cell counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase <= lbm_pkg::IDLE;
            cell_idx <= '0;
            cell_col <= '0;
            bank_cur <= 1'b0;
            wr_pend <= 1'b0;
            bnc_wr <= 1'b0;
        end
        else
        begin
            wr_pend <= 1'b0;
            bnc_wr <= 1'b0;
            case (phase)
                lbm_pkg::IDLE:
                begin
                    if (cmd_fire)
                        phase <= (cmd_op == lbm_pkg::OP_INIT) ? lbm_pkg::INIT : lbm_pkg::STREAM;
                end
                lbm_pkg::INIT:
                begin
                    cell_idx <= last_cell ? '0 : next_idx;
                    cell_col <= last_cell ? '0 : next_col;
                    if (last_cell)
                        phase <= lbm_pkg::IDLE;
                end
                lbm_pkg::STREAM:
                begin
                    // one extra cycle flushes the last write
                    if (cell_idx == lbm_pkg::cell_addr_t'(`LBM_CELLS))
                    begin
                        phase <= lbm_pkg::BOUNCE;
                        cell_idx <= '0;
                        cell_col <= '0;
                    end
                    else
                    begin
                        wr_pend <= 1'b1;
                        cell_idx <= next_idx;
                        cell_col <= next_col;
                    end
                end
                lbm_pkg::BOUNCE:
                begin
                    // barrier cell, hold one cycle for the read
                    if (barriers[cell_idx] && !bnc_wr)
                        bnc_wr <= 1'b1;
                    else
                    begin
                        cell_idx <= last_cell ? '0 : next_idx;
                        cell_col <= last_cell ? '0 : next_col;
                        if (last_cell)
                            phase <= lbm_pkg::CLEAR;
                    end
                end
                lbm_pkg::CLEAR:
                begin
                    cell_idx <= last_cell ? '0 : next_idx;
                    cell_col <= last_cell ? '0 : next_col;
                    if (last_cell)
                    begin
                        phase <= lbm_pkg::IDLE;
                        // next bank becomes current
                        bank_cur <= !bank_cur;
                    end
                end
                default:
                    phase <= lbm_pkg::IDLE;
            endcase
        end
    end

    // write stage payload, qualified by wr_pend or bnc_wr
    always_ff @(posedge clk)
    begin
        pend_cell <= cell_idx;
        pend_ok <= up_ok;
        pend_up <= up_addr;
        pend_en <= up_fluid;
    end

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        plane_we = '0;
        plane_wdata = '0;
        for (int d = 0; d < `LBM_DIRS; d++)
            plane_waddr[d] = cell_idx;
        case (phase)
            lbm_pkg::INIT:
            begin
                // both banks, barrier cells start empty
                for (int d = 0; d < `LBM_DIRS; d++)
                begin
                    plane_we[d] = 2'b11;
                    plane_wdata[d] = barriers[cell_idx] ? '0 : init_dist[d];
                end
            end
            lbm_pkg::STREAM:
            begin
                // pull, zero inflow from off the grid
                for (int d = 0; d < `LBM_DIRS; d++)
                begin
                    plane_we[d] = {1'b0, wr_pend};
                    plane_waddr[d] = pend_cell;
                    plane_wdata[d] = pend_ok[d] ? plane_q[d] : '0;
                end
            end
            lbm_pkg::BOUNCE:
            begin
                // reflect into the fluid cell it came from
                // rest plane never bounces
                for (int d = 1; d < `LBM_DIRS; d++)
                begin
                    plane_we[d] = {1'b0, bnc_wr && pend_en[OPP[d]]};
                    plane_waddr[d] = pend_up[OPP[d]];
                    plane_wdata[d] = plane_q[OPP[d]];
                end
            end
            lbm_pkg::CLEAR:
            begin
                // wipe barrier cells in the next bank
                for (int d = 0; d < `LBM_DIRS; d++)
                    plane_we[d] = {1'b0, barriers[cell_idx]};
            end
            default:
            begin
            end
        endcase
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module lbm_solver_tb -o lbm_sim

out=$(./obj_dir/lbm_sim 2>&1 || true)
printf '%s\n' "$out"

# pass only when the testbench printed its pass line
printf '%s\n' "$out" | grep -q "Test OK"

// File: sim.f
+incdir+hw
hw/lbm_pkg.sv
hw/dist_plane.sv
hw/neighbor_map.sv
hw/readout_port.sv
hw/sweep_sequencer.sv
hw/lbm_solver.sv
tests/lbm_solver_sva.sv
tests/lbm_solver_tb.sv

// File: tests/lbm_solver_sva.sv
`timescale 1ns/1ps
`include "lbm_consts.svh"

module lbm_solver_sva (
    input logic                      clk,
    input logic                      arst_n,
    input logic                      cmd_valid,
    input logic                      cmd_ready,
    input logic                      idle,
    input logic                      rsp_valid,
    input logic                      rsp_ready,
    input lbm_pkg::dist_vec_t        rsp_data,
    input logic [`LBM_DIRS-1:0][1:0] plane_we
);

    // busy cycles with ready low since the sweep began
    logic [7:0] sweep_len;

    // count restarts whenever ready shows up
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            sweep_len <= '0;
        else if (idle || cmd_ready)
            sweep_len <= '0;
        else
            sweep_len <= sweep_len + 1'b1;
    end

    // accepted command leaves idle on the next edge
    a_cmd_leaves_idle: assert property (@(posedge clk) disable iff (!arst_n)
        (cmd_valid && cmd_ready) |=> !idle)
        else $error("sweep did not start after an accepted command");

    // ready held low through at least one full pass over the grid
    a_sweep_ready_low: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(idle) |-> (sweep_len >= `LBM_CELLS))
        else $error("cmd_ready came back before the sweep covered the grid");

    // stalled response keeps its data
    a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data)))
        else $error("response dropped or changed under back-pressure");

    // planes untouched while idle
    a_idle_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        idle |-> (plane_we == '0))
        else $error("plane write enabled in idle phase");

endmodule

bind lbm_solver lbm_solver_sva lbm_solver_sva_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .idle      (idle),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data),
    .plane_we  (plane_we)
);

// File: tests/lbm_solver_tb.sv
`timescale 1ns/1ps
`include "lbm_consts.svh"

module lbm_solver_tb;

    localparam int TIMEOUT_CYCLES = 2000;
    // step per direction with rows growing southward
    // rest, n, ne, e, se, s, sw, w, nw
    localparam int COL_STEP [`LBM_DIRS] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
    localparam int ROW_STEP [`LBM_DIRS] = '{0, -1, -1, 0, 1, 1, 1, 0, -1};

    logic                  clk;
    logic                  arst_n;
    logic                  cmd_valid;
    lbm_pkg::cmd_op_t      cmd_op;
    logic                  cmd_ready;
    logic [`LBM_CELLS-1:0] barriers;
    lbm_pkg::dist_vec_t    init_dist;
    logic                  rd_valid;
    lbm_pkg::cell_addr_t   rd_addr;
    logic                  rd_ready;
    logic                  rsp_valid;
    lbm_pkg::dist_vec_t    rsp_data;
    logic                  rsp_ready;

    // software lattice for the current and next time level
    lbm_pkg::dist_t   cur_m [`LBM_CELLS][`LBM_DIRS];
    lbm_pkg::dist_t   nxt_m [`LBM_CELLS][`LBM_DIRS];
    int               seed_ret;
    int               n;
    lbm_pkg::cmd_op_t rand_op;

    lbm_solver lbm_solver_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_ready (cmd_ready),
        .barriers  (barriers),
        .init_dist (init_dist),
        .rd_valid  (rd_valid),
        .rd_addr   (rd_addr),
        .rd_ready  (rd_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_ready (rsp_ready)
    );

    // 100 ns period
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    ////////////////////////////////////////////////////////////
    // lattice model
    ////////////////////////////////////////////////////////////

    // source cell of direction d or false when off the grid
    function automatic bit upstream_cell(input int c, input int d, output int u);
        int ur;
        int uc;
        ur = c / `LBM_WIDTH - ROW_STEP[d];
        uc = c % `LBM_WIDTH - COL_STEP[d];
        u = ur * `LBM_WIDTH + uc;
        return (ur >= 0) && (ur < `LBM_HEIGHT) && (uc >= 0) && (uc < `LBM_WIDTH);
    endfunction

    // four places further round the compass
    function automatic int opposite(input int d);
        return ((d + 3) % 8) + 1;
    endfunction

    function automatic void model_init();
        for (int c = 0; c < `LBM_CELLS; c++)
            for (int d = 0; d < `LBM_DIRS; d++)
                cur_m[c][d] = barriers[c] ? '0 : init_dist[d];
    endfunction

    function automatic void model_step();
        int u;
        // pull stream with zero inflow from outside
        for (int c = 0; c < `LBM_CELLS; c++)
            for (int d = 0; d < `LBM_DIRS; d++)
            begin
                nxt_m[c][d] = '0;
                if (upstream_cell(c, d, u))
                    nxt_m[c][d] = cur_m[u][d];
            end
        // barrier sends each mover back where it came from
        for (int c = 0; c < `LBM_CELLS; c++)
            if (barriers[c])
                for (int d = 1; d < `LBM_DIRS; d++)
                    if (upstream_cell(c, d, u) && !barriers[u])
                        nxt_m[u][opposite(d)] = nxt_m[c][d];
        for (int c = 0; c < `LBM_CELLS; c++)
            if (barriers[c])
                for (int d = 0; d < `LBM_DIRS; d++)
                    nxt_m[c][d] = '0;
        // bank swap
        cur_m = nxt_m;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus and checks
    ////////////////////////////////////////////////////////////

    function automatic void randomize_grid();
        for (int c = 0; c < `LBM_CELLS; c++)
            barriers[c] = ($urandom_range(0, 4) == 0);
        for (int d = 0; d < `LBM_DIRS; d++)
            init_dist[d] = lbm_pkg::dist_t'($urandom);
    endfunction

    task automatic wait_cmd_ready(input string name);
        int cnt;
        cnt = 0;
        while (!cmd_ready)
        begin
            if (cnt == TIMEOUT_CYCLES)
            begin
                $display("%s: sweep never finished, cmd_ready stayed low", name);
                stop_on_error();
            end
            cnt++;
            @(negedge clk);
        end
    endtask

    // hold keeps cmd_valid up during the sweep, which must be ignored
    task automatic apply_cmd(input lbm_pkg::cmd_op_t op, input int hold, input string name);
        int i;
        @(negedge clk);
        wait_cmd_ready(name);
        cmd_valid = 1'b1;
        cmd_op = op;
        @(negedge clk);
        for (i = 0; i < hold; i++)
        begin
            assert (!cmd_ready)
            else
            begin
                $display("ERROR %s: cmd_ready in sweep, expected 0 actual %0b", name, cmd_ready);
                stop_on_error();
            end
            @(negedge clk);
        end
        cmd_valid = 1'b0;
        wait_cmd_ready(name);
        if (op == lbm_pkg::OP_INIT)
            model_init();
        else
            model_step();
    endtask

    // read every cell in order under random back-pressure
    task automatic read_cells(input string name);
        int                 sent;
        int                 got;
        int                 cnt;
        int                 a;
        int                 q_addr[$];
        lbm_pkg::dist_vec_t exp_v;
        sent = 0;
        got = 0;
        cnt = 0;
        while (got < `LBM_CELLS)
        begin
            @(negedge clk);
            rsp_ready = ($urandom_range(0, 1) == 1);
            rd_valid = (sent < `LBM_CELLS);
            rd_addr = lbm_pkg::cell_addr_t'(sent);
            // settle then look at what the next edge will take
            #10;
            if (rsp_valid && rsp_ready)
            begin
                if (q_addr.size() == 0)
                begin
                    $display("%s: response arrived with no request outstanding", name);
                    stop_on_error();
                end
                a = q_addr.pop_front();
                for (int d = 0; d < `LBM_DIRS; d++)
                    exp_v[d] = cur_m[a][d];
                assert (rsp_data == exp_v)
                else
                begin
                    $display("ERROR %s cell %0d: expected %h actual %h", name, a, exp_v, rsp_data);
                    stop_on_error();
                end
                got++;
            end
            if (rd_valid && rd_ready)
            begin
                q_addr.push_back(sent);
                sent++;
            end
            cnt++;
            if (cnt == TIMEOUT_CYCLES)
            begin
                $display("%s: readout stalled, %0d of %0d responses seen", name, got, `LBM_CELLS);
                stop_on_error();
            end
        end
        @(negedge clk);
        rd_valid = 1'b0;
        rsp_ready = 1'b0;
    endtask

    initial
    begin
        seed_ret = $urandom(32'h1e25_6858);
        cmd_valid = 1'b0;
        cmd_op = lbm_pkg::OP_INIT;
        barriers = '0;
        init_dist = '0;
        rd_valid = 1'b0;
        rd_addr = '0;
        rsp_ready = 1'b0;
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (cmd_ready && rd_ready && !rsp_valid)
        else
        begin
            $display("ERROR reset: expected ready 1 1 valid 0, actual %0b %0b %0b",
                     cmd_ready, rd_ready, rsp_valid);
            stop_on_error();
        end

        // init with random barriers
        randomize_grid();
        apply_cmd(lbm_pkg::OP_INIT, 0, "init");
        read_cells("init");

        // open grid where the edges pull in zero
        randomize_grid();
        barriers = '0;
        apply_cmd(lbm_pkg::OP_INIT, 0, "stream");
        apply_cmd(lbm_pkg::OP_STEP, 0, "stream");
        read_cells("stream");

        // bounce-back over several steps
        randomize_grid();
        apply_cmd(lbm_pkg::OP_INIT, 0, "bounce");
        for (n = 0; n < 3; n++)
        begin
            apply_cmd(lbm_pkg::OP_STEP, 0, "bounce");
            read_cells("bounce");
        end

        // random command mix with valid held into the sweep
        for (n = 0; n < 12; n++)
        begin
            rand_op = ($urandom_range(0, 2) == 0) ? lbm_pkg::OP_INIT : lbm_pkg::OP_STEP;
            if (rand_op == lbm_pkg::OP_INIT)
                randomize_grid();
            apply_cmd(rand_op, $urandom_range(0, 6), "sequence");
            read_cells("sequence");
        end

        // repeated readout under back-pressure
        apply_cmd(lbm_pkg::OP_STEP, 8, "hold");
        read_cells("backpressure");
        read_cells("backpressure");

        $display("Test OK");
        $finish;
    end

endmodule
